// File: joystick_port.f
source/joy_cfg_pkg.sv
source/joy_types_pkg.sv
source/axis_pos_if.sv
source/frac_tick_gen.sv
source/stick_position.sv
source/axis_timer.sv
source/grip_serializer.sv
source/joystick_port.sv
dv/joystick_port_tb.sv

// File: Bender.yml
package:
  name: joystick_port

sources:
  - source/joy_cfg_pkg.sv
  - source/joy_types_pkg.sv
  - source/axis_pos_if.sv
  - source/frac_tick_gen.sv
  - source/stick_position.sv
  - source/axis_timer.sv
  - source/grip_serializer.sv
  - source/joystick_port.sv
  - target: test
    files:
      - dv/joystick_port_tb.sv

// File: dv/joystick_port_tb.sv
/*
 * Game-port joystick adapter testbench
 * Table-driven axis, button and GrIP checks on the port register
 */
`timescale 1ns/1ps

module joystick_port_tb;

  localparam int CLK_PERIOD      = 4;                // ns
  localparam int CLOCK_RATE      = 3636364;          // 1.1 us tick every 4 cycles
  localparam int GRIP_HALF       = CLOCK_RATE / joy_cfg_pkg::GRIP_STEP + 1;
  localparam int GRIP_CYCLES     = 52 * 2 * GRIP_HALF; // Two frames plus slack
  localparam int ROW_CYCLES      = 4 * 1023 + 64;      // Longest timed one-shot
  localparam int N_ROWS          = 12;
  localparam int WATCHDOG_CYCLES = N_ROWS * ROW_CYCLES + GRIP_CYCLES + 100;

  logic                       clk = 1'b0;
  logic                       rst_n;
  joy_types_pkg::rate_t       clock_rate;
  joy_types_pkg::pad_bits_t   dig_1;
  joy_types_pkg::pad_bits_t   dig_2;
  joy_types_pkg::stick_word_t ana_1;
  joy_types_pkg::stick_word_t ana_2;
  joy_cfg_pkg::pad_mode_e     mode;
  joy_cfg_pkg::count_mode_e   timed;
  logic [1:0]                 dis;
  logic                       read;
  logic                       write;
  joy_types_pkg::port_byte_t  readdata;

  integer seed = 37512;
  int     byte_errors  = 0;
  int     count_errors = 0;
  int     other_errors = 0;

  // One stimulus row; axis rows write and time the one-shots, others check buttons
  typedef struct packed {
    logic                       axis;
    joy_cfg_pkg::pad_mode_e     mode;
    joy_cfg_pkg::count_mode_e   timed;
    logic [1:0]                 dis;
    joy_types_pkg::pad_bits_t   dig_1;
    joy_types_pkg::pad_bits_t   dig_2;
    joy_types_pkg::stick_word_t ana_1;
    joy_types_pkg::stick_word_t ana_2;
    logic [31:0]                pos;   // Expected {j2y, j2x, j1y, j1x}
  } row_t;

  localparam row_t ROWS [N_ROWS] = '{
    '{1'b1, joy_cfg_pkg::two_button, joy_cfg_pkg::count_0_256, 2'b00,
      14'h0009, 14'h0006, 16'h0000, 16'h0000, 32'hFF0000FF},  // D-pad corners
    '{1'b1, joy_cfg_pkg::four_button, joy_cfg_pkg::count_6_256, 2'b00,
      14'h0000, 14'h0009, 16'h0000, 16'h0000, 32'h00FF8080},  // P1 centered
    '{1'b1, joy_cfg_pkg::two_button, joy_cfg_pkg::count_8_141, 2'b00,
      14'h0000, 14'h0000, 16'h64A6, 16'h807F, 32'h00FFE426},  // Both go analog
    '{1'b1, joy_cfg_pkg::two_button, joy_cfg_pkg::count_0_256, 2'b00,
      14'h0000, 14'h0000, 16'h10C0, 16'h3D00, 32'hBD809040},  // Just past +-60
    '{1'b1, joy_cfg_pkg::four_button, joy_cfg_pkg::count_6_256, 2'b00,
      14'h0004, 14'h0002, 16'h3C00, 16'hC305, 32'h4385FF80},  // P1 back to d-pad
    '{1'b1, joy_cfg_pkg::two_button, joy_cfg_pkg::timed_ibm, 2'b00,
      14'h0006, 14'h0000, 16'h0000, 16'h0000, 32'h8080FF00},  // Positions 0, 255, 128
    '{1'b0, joy_cfg_pkg::two_button, joy_cfg_pkg::timed_ibm, 2'b00, '0, '0, '0, '0, '0},
    '{1'b0, joy_cfg_pkg::two_button, joy_cfg_pkg::timed_ibm, 2'b01, '0, '0, '0, '0, '0},
    '{1'b0, joy_cfg_pkg::two_button, joy_cfg_pkg::timed_ibm, 2'b11, '0, '0, '0, '0, '0},
    '{1'b0, joy_cfg_pkg::four_button, joy_cfg_pkg::timed_ibm, 2'b10, '0, '0, '0, '0, '0},
    '{1'b0, joy_cfg_pkg::four_button, joy_cfg_pkg::timed_ibm, 2'b11, '0, '0, '0, '0, '0},
    '{1'b0, joy_cfg_pkg::no_stick, joy_cfg_pkg::timed_ibm, 2'b00, '0, '0, '0, '0, '0}
  };

  joystick_port joystick_port_inst (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_byte(input string name, input joy_types_pkg::port_byte_t exp,
                            input joy_types_pkg::port_byte_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %02h, actual %02h", name, exp, act);
      byte_errors++;
    end
  endtask

  task automatic check_count(input string name, input joy_types_pkg::axis_count_t exp,
                             input joy_types_pkg::axis_count_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
      count_errors++;
    end
  endtask

  // One-shot length for a position under each count method
  function automatic joy_types_pkg::axis_count_t expected_count(
    input joy_cfg_pkg::count_mode_e m,
    input int                       p
  );
    int c;
    case (m)
      joy_cfg_pkg::timed_ibm:   c = (p == 255) ? 1022 : 22 + 4 * p - p / 16 - p / 64;
      joy_cfg_pkg::count_8_141: c = 8 + p / 2 + p / 16 - 2 * (p / 128);
      joy_cfg_pkg::count_0_256: c = p;
      default:                  c = p + 6;
    endcase
    return joy_types_pkg::axis_count_t'(c);
  endfunction

  // Port byte with all one-shots expired
  function automatic joy_types_pkg::port_byte_t expected_port(
    input joy_cfg_pkg::pad_mode_e   m,
    input logic [1:0]               d,
    input joy_types_pkg::pad_bits_t p1,
    input joy_types_pkg::pad_bits_t p2
  );
    logic [3:0] btn;
    logic       keep34;
    if (m == joy_cfg_pkg::no_stick) return 8'hFF;
    btn    = (m == joy_cfg_pkg::four_button) ? ~p1[7:4] : ~{p2[5:4], p1[5:4]};
    keep34 = (m == joy_cfg_pkg::four_button) && (d == 2'b10); // 4-button pad, P2 off
    return {btn, 4'b0000} | {{2{d[1] & ~keep34}}, {2{d[0]}}, {2{d[1]}}, {2{d[0]}}};
  endfunction

  // GrIP frame, slot 0 in the MSB
  function automatic logic [23:0] grip_frame(input joy_types_pkg::pad_bits_t d);
    return {1'b0, 5'b11111, 1'b0, d[9], d[8], d[12], d[7], 1'b0, d[13], d[5], d[4], d[6],
            1'b0, d[11], d[10], d[3], d[2], 1'b0, d[0], d[1]};
  endfunction

  // First sample index of a 0 followed by five 1s, -1 when none
  function automatic int find_header(input logic [47:0] b);
    int h;
    h = -1;
    for (int i = 23; i >= 0; i--) begin
      if (!b[i] && b[i + 1 +: 5] == 5'b11111) h = i;
    end
    return h;
  endfunction

  // Write, then step until every axis bit reads 0
  task automatic measure_axes(input int r);
    int                       done_at [4];
    int                       k;
    joy_types_pkg::axis_pos_t p;
    for (int i = 0; i < 4; i++) done_at[i] = -1;
    k = 0;
    repeat (2) @(posedge clk);     // D-pad/analog flag settles
    write <= 1'b1;
    @(posedge clk);
    write <= 1'b0;                 // Counts load on this edge
    @(posedge clk);                // readdata carries the new counts after this
    while (k < 4200 &&
           (done_at[0] < 0 || done_at[1] < 0 || done_at[2] < 0 || done_at[3] < 0)) begin
      @(negedge clk);
      for (int i = 0; i < 4; i++) begin
        if (done_at[i] < 0 && !readdata[i]) done_at[i] = k;
      end
      if (ROWS[r].timed == joy_cfg_pkg::timed_ibm) begin
        @(posedge clk);            // One cycle per step, tick every 4
      end else begin
        @(posedge clk);
        read <= 1'b1;
        @(posedge clk);
        read <= 1'b0;
        repeat (2) @(posedge clk); // Falling edge seen late, then readdata
      end
      k++;
    end
    for (int i = 0; i < 4; i++) begin
      p = ROWS[r].pos[8 * i +: 8];
      if (done_at[i] < 0) begin
        $display("Row %0d axis %0d never cleared after the write", r, i);
        other_errors++;
      end else begin
        // Timed bit drops 4*count+1 samples in, so /4 keeps a one-cycle margin
        check_count($sformatf("row %0d axis %0d", r, i), expected_count(ROWS[r].timed, p),
                    joy_types_pkg::axis_count_t'((ROWS[r].timed == joy_cfg_pkg::timed_ibm) ?
                                                 done_at[i] / 4 : done_at[i]));
      end
    end
  endtask

  task automatic apply_row(input int r);
    integer rnd_1;
    integer rnd_2;
    @(posedge clk);
    mode  <= ROWS[r].mode;
    timed <= ROWS[r].timed;
    dis   <= ROWS[r].dis;
    ana_1 <= ROWS[r].ana_1;
    ana_2 <= ROWS[r].ana_2;
    if (ROWS[r].axis) begin
      dig_1 <= ROWS[r].dig_1;
      dig_2 <= ROWS[r].dig_2;
      measure_axes(r);
    end else begin
      rnd_1 = $random(seed);
      rnd_2 = $random(seed);
      dig_1 <= rnd_1[13:0];        // Random buttons
      dig_2 <= rnd_2[13:0];
      repeat (3) @(posedge clk);   // Button register, then readdata
      @(negedge clk);
      check_byte($sformatf("row %0d", r),
                 expected_port(ROWS[r].mode, ROWS[r].dis, rnd_1[13:0], rnd_2[13:0]), readdata);
    end
  endtask

  // Sample each player's data on the falling edge of its own GrIP clock line
  task automatic decode_grip_frames();
    integer      rnd_1;
    integer      rnd_2;
    logic [47:0] bits_1;  // Index is sample order
    logic [47:0] bits_2;
    logic [23:0] frame_1;
    logic [23:0] frame_2;
    logic [23:0] exp_1;
    logic [23:0] exp_2;
    logic        clk_last_1;
    logic        clk_last_2;
    int          n_1;
    int          n_2;
    int          cyc;
    int          hdr_1;
    int          hdr_2;
    rnd_1 = $random(seed);
    rnd_2 = $random(seed);
    @(posedge clk);
    mode  <= joy_cfg_pkg::gravis_pro;
    dis   <= 2'b00;
    dig_1 <= rnd_1[13:0];
    dig_2 <= rnd_2[13:0];
    repeat (4) @(posedge clk);
    @(negedge clk);
    clk_last_1 = readdata[4];     // Player 1 clock on button 1
    clk_last_2 = readdata[6];     // Player 2 clock on button 3
    n_1   = 0;
    n_2   = 0;
    cyc   = 0;
    hdr_1 = -1;
    hdr_2 = -1;
    while ((n_1 < 48 || n_2 < 48) && cyc < GRIP_CYCLES) begin
      @(negedge clk);
      cyc++;
      if (n_1 < 48 && clk_last_1 && !readdata[4]) begin
        bits_1[n_1] = readdata[5];  // Player 1 on button 2
        n_1++;
      end
      if (n_2 < 48 && clk_last_2 && !readdata[6]) begin
        bits_2[n_2] = readdata[7];  // Player 2 on button 4
        n_2++;
      end
      clk_last_1 = readdata[4];
      clk_last_2 = readdata[6];
    end
    if (n_1 == 48) hdr_1 = find_header(bits_1);
    if (n_2 == 48) hdr_2 = find_header(bits_2);
    if (hdr_1 < 0 || hdr_2 < 0) begin
      $display("GrIP frame not found, clock stopped or header missing");
      other_errors++;
    end else begin
      exp_1 = grip_frame(rnd_1[13:0]);
      exp_2 = grip_frame(rnd_2[13:0]);
      for (int j = 0; j < 24; j++) begin
        frame_1[23 - j] = bits_1[hdr_1 + j];
        frame_2[23 - j] = bits_2[hdr_2 + j];
      end
      for (int s = 0; s < 3; s++) begin
        check_byte($sformatf("grip player 1 slots %0d-%0d", 8 * s, 8 * s + 7),
                   exp_1[23 - 8 * s -: 8], frame_1[23 - 8 * s -: 8]);
        check_byte($sformatf("grip player 2 slots %0d-%0d", 8 * s, 8 * s + 7),
                   exp_2[23 - 8 * s -: 8], frame_2[23 - 8 * s -: 8]);
      end
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    clock_rate = CLOCK_RATE;
    dig_1      = '0;
    dig_2      = '0;
    ana_1      = '0;
    ana_2      = '0;
    mode       = joy_cfg_pkg::two_button;
    timed      = joy_cfg_pkg::count_0_256;
    dis        = 2'b00;
    read       = 1'b0;
    write      = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    for (int r = 0; r < N_ROWS; r++) apply_row(r);
    decode_grip_frames();
    $display("Errors: %0d byte, %0d count, %0d other", byte_errors, count_errors,
             other_errors);
    if (byte_errors + count_errors + other_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Bound by the table length and the longest one-shot
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

// File: source/joystick_port.sv
/*
 * PC game-port joystick adapter
 * Builds the 8-bit game-port register from two pads and two analog sticks
 */
`timescale 1ns/1ps

module joystick_port #(
  parameter joy_types_pkg::rate_t GRIP_STEP = joy_cfg_pkg::GRIP_STEP,
  parameter joy_types_pkg::rate_t TICK_STEP = joy_cfg_pkg::TICK_STEP
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  joy_types_pkg::rate_t       clock_rate, // Hz
  input  joy_types_pkg::pad_bits_t   dig_1,
  input  joy_types_pkg::pad_bits_t   dig_2,
  input  joy_types_pkg::stick_word_t ana_1,
  input  joy_types_pkg::stick_word_t ana_2,
  input  joy_cfg_pkg::pad_mode_e     mode,
  input  joy_cfg_pkg::count_mode_e   timed,
  input  logic [1:0]                 dis,   // Per-player disable
  input  logic                       read,
  input  logic                       write,
  output joy_types_pkg::port_byte_t  readdata
);

  logic       grip_pulse;
  logic       tick;
  logic       grip_clk;
  logic [1:0] grip_data;
  logic [3:0] active;  // Axis one-shots running
  logic [3:0] btn;     // Active low, btn[0] is button 1
  logic       dis_b34; // Mask buttons 3/4

  axis_pos_if pos_bus ();

  frac_tick_gen #(.STEP(GRIP_STEP)) grip_gen_inst (
    .clk        (clk),
    .clock_rate (clock_rate),
    .clear      (1'b0),       // Free running
    .pulse      (grip_pulse)
  );

  frac_tick_gen #(.STEP(TICK_STEP)) tick_gen_inst (
    .clk        (clk),
    .clock_rate (clock_rate),
    .clear      (write),      // Align tick phase to the write
    .pulse      (tick)
  );

  stick_position stick_position_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .dig_1 (dig_1),
    .dig_2 (dig_2),
    .ana_1 (ana_1),
    .ana_2 (ana_2),
    .write (write),
    .pos   (pos_bus.source)
  );

  axis_timer axis_timer_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .timed  (timed),
    .tick   (tick),
    .read   (read),
    .pos    (pos_bus.sink),
    .active (active)
  );

  grip_serializer grip_serializer_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .pulse     (grip_pulse),
    .dig_1     (dig_1),
    .dig_2     (dig_2),
    .grip_clk  (grip_clk),
    .grip_data (grip_data)
  );

  // Button lines, released = 1
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      btn <= 4'b1111;
    end else if (mode == joy_cfg_pkg::gravis_pro) begin
      btn <= {grip_data[1], grip_clk, grip_data[0], grip_clk}; // Clock on 1/3, data on 2/4
    end else if (mode == joy_cfg_pkg::four_button) begin
      btn <= ~dig_1[7:4];
    end else begin
      btn <= ~{dig_2[5:4], dig_1[5:4]}; // Player 2 buttons on 3/4
    end
  end

  // Four-button pad keeps 3/4 even with player 2 off
  assign dis_b34 = dis[1] && !(mode == joy_cfg_pkg::four_button && dis == 2'b10);

  always_ff @(posedge clk) begin
    if (mode == joy_cfg_pkg::no_stick) begin
      readdata <= 8'hFF;
    end else begin
      readdata <= {btn, active} |
                  {{2{dis_b34}}, {2{dis[0]}}, {2{dis[1]}}, {2{dis[0]}}}; // Disabled reads 1
    end
  end

endmodule

// File: source/grip_serializer.sv
/*
 * Gravis GamePad Pro (GrIP) serializer
 * Drives the GrIP clock and a 24-slot frame per player on the data lines
 */
`timescale 1ns/1ps

module grip_serializer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     pulse,     // Half-period pulse, 40 kHz
  input  joy_types_pkg::pad_bits_t dig_1,
  input  joy_types_pkg::pad_bits_t dig_2,
  output logic                     grip_clk,  // Host samples data on its falling edge
  output logic [1:0]               grip_data  // {player 2, player 1}, 1 = held
);

  logic [4:0] grip_pos; // Slot 0..23

  // Frame is a 0, five 1s, then groups of pad bits each led by a 0
  function automatic logic slot_bit(
    input joy_types_pkg::pad_bits_t d,
    input logic [4:0]               s
  );
    case (s)
      5'd0, 5'd6, 5'd11, 5'd16, 5'd21: return 1'b0; // Header start and group leaders
      5'd1, 5'd2, 5'd3, 5'd4, 5'd5:    return 1'b1;
      5'd7:  return d[9];  // Select
      5'd8:  return d[8];  // Start
      5'd9:  return d[12]; // R2
      5'd10: return d[7];  // but4
      5'd12: return d[13]; // L2
      5'd13: return d[5];  // but2
      5'd14: return d[4];  // but1
      5'd15: return d[6];  // but3
      5'd17: return d[11]; // L1
      5'd18: return d[10]; // R1
      5'd19: return d[3];  // Up
      5'd20: return d[2];  // Down
      5'd22: return d[0];  // Right
      default: return d[1]; // Slot 23, left
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      grip_clk  <= 1'b0;
      grip_pos  <= 5'd0;
      grip_data <= 2'b00;
    end else if (pulse) begin
      grip_clk <= ~grip_clk;
      // Low going high, so present the next slot
      if (!grip_clk) begin
        grip_pos  <= (grip_pos == 5'd23) ? 5'd0 : grip_pos + 5'd1;
        grip_data <= {slot_bit(dig_2, grip_pos), slot_bit(dig_1, grip_pos)};
      end
    end
  end

endmodule

// File: source/axis_timer.sv
/*
 * Axis one-shot timers
 * Loads four counts from the positions on a port write, then counts them down
 */
`timescale 1ns/1ps

module axis_timer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  joy_cfg_pkg::count_mode_e  timed,  // Count method
  input  logic                      tick,   // 1.1 us tick
  input  logic                      read,   // Port read strobe
  axis_pos_if.sink                  pos,
  output logic [3:0]                active  // {j2y, j2x, j1y, j1x} still running
);

  joy_types_pkg::axis_count_t cnt [4]; // Index 0 j1x, 1 j1y, 2 j2x, 3 j2y
  joy_types_pkg::axis_pos_t   pos_in [4];
  logic                       read_last;
  logic                       step;

  // One-shot length for a position under the selected method
  function automatic joy_types_pkg::axis_count_t map_count(
    input joy_cfg_pkg::count_mode_e m,
    input joy_types_pkg::axis_pos_t p
  );
    joy_types_pkg::axis_count_t w;
    w = joy_types_pkg::axis_count_t'(p);
    case (m)
      // 22 + pos * 1000/255, 4 - 1/16 - 1/64 approximates 3.92
      joy_cfg_pkg::timed_ibm:   return (p == 8'd255) ? 11'd1022 :
                                       11'd22 + (w << 2) - (w >> 4) - (w >> 6);
      joy_cfg_pkg::count_8_141: return 11'd8 + (w >> 1) + (w >> 4) - ((w >> 7) << 1);
      joy_cfg_pkg::count_0_256: return w;
      default:                  return w + 11'd6; // count_6_256
    endcase
  endfunction

  assign pos_in[0] = pos.j1x;
  assign pos_in[1] = pos.j1y;
  assign pos_in[2] = pos.j2x;
  assign pos_in[3] = pos.j2y;

  // Tick in timed mode, else falling edge of read (one cycle late)
  assign step = (timed == joy_cfg_pkg::timed_ibm) ? tick : (read_last & ~read);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      read_last <= 1'b0;
      for (int i = 0; i < 4; i++) begin
        cnt[i] <= 11'd128; // Center
      end
    end else begin
      read_last <= read;
      for (int i = 0; i < 4; i++) begin
        if (pos.load) begin
          cnt[i] <= map_count(timed, pos_in[i]); // New measurement wins over a step
        end else if (step && (cnt[i] != '0)) begin
          cnt[i] <= cnt[i] - 11'd1;
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      active[i] = |cnt[i];
    end
  end

endmodule

// File: source/stick_position.sv
/*
 * Stick position selector
 * Picks d-pad or analog input per player and converts each axis to 0..255
 */
`timescale 1ns/1ps

module stick_position (
  input  logic                       clk,
  input  logic                       rst_n,
  input  joy_types_pkg::pad_bits_t   dig_1,
  input  joy_types_pkg::pad_bits_t   dig_2,
  input  joy_types_pkg::stick_word_t ana_1,
  input  joy_types_pkg::stick_word_t ana_2,
  input  logic                       write, // Port write starts a measurement
  axis_pos_if.source                 pos
);

  logic use_dpad_1; // 1 = d-pad, 0 = analog
  logic use_dpad_2;
  logic active_1;   // Stick deflected past threshold
  logic active_2;

  // True when one signed axis is outside the dead band
  function automatic logic over_threshold(input logic signed [7:0] v);
    return (v < -joy_cfg_pkg::ACTIVITY_THRESHOLD) ||
           (v > joy_cfg_pkg::ACTIVITY_THRESHOLD);
  endfunction

  // Axis position from stick or from the two opposing d-pad lines
  function automatic joy_types_pkg::axis_pos_t map_axis(
    input logic       use_dpad,
    input logic [7:0] ana,
    input logic       dir_low,  // Left or up
    input logic       dir_high  // Right or down
  );
    if (!use_dpad) begin
      return {~ana[7], ana[6:0]}; // Signed -128..127 to offset binary
    end else if (dir_low) begin
      return 8'd0;
    end else if (dir_high) begin
      return 8'd255;
    end
    return 8'd128; // Centered
  endfunction

  assign active_1 = over_threshold(ana_1[7:0]) || over_threshold(ana_1[15:8]);
  assign active_2 = over_threshold(ana_2[7:0]) || over_threshold(ana_2[15:8]);

  // Analog wins; d-pad only reclaims the player when the stick is idle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      use_dpad_1 <= 1'b1;
      use_dpad_2 <= 1'b1;
    end else begin
      if (active_1) begin
        use_dpad_1 <= 1'b0;
      end else if (|dig_1[3:0]) begin
        use_dpad_1 <= 1'b1;
      end
      if (active_2) begin
        use_dpad_2 <= 1'b0;
      end else if (|dig_2[3:0]) begin
        use_dpad_2 <= 1'b1;
      end
    end
  end

  // Positions are combinational, sampled by the timer on load
  assign pos.j1x  = map_axis(use_dpad_1, ana_1[7:0],  dig_1[1], dig_1[0]);
  assign pos.j1y  = map_axis(use_dpad_1, ana_1[15:8], dig_1[3], dig_1[2]);
  assign pos.j2x  = map_axis(use_dpad_2, ana_2[7:0],  dig_2[1], dig_2[0]);
  assign pos.j2y  = map_axis(use_dpad_2, ana_2[15:8], dig_2[3], dig_2[2]);
  assign pos.load = write;

endmodule

// File: source/frac_tick_gen.sv
/*
 * Fractional rate pulse generator
 * Emits one-cycle pulses at STEP Hz for a clock of clock_rate Hz
 */
`timescale 1ns/1ps

module frac_tick_gen #(
  parameter joy_types_pkg::rate_t STEP = joy_cfg_pkg::TICK_STEP
) (
  input  logic                 clk,
  input  joy_types_pkg::rate_t clock_rate, // System clock in Hz
  input  logic                 clear,      // Restart phase
  output logic                 pulse = 1'b0
);

  joy_types_pkg::rate_t acc = '0; // Phase accumulator, free running
  joy_types_pkg::rate_t acc_next;

  // Clear restarts from zero, so no pulse in the clearing cycle
  always_comb begin
    acc_next = clear ? '0 : acc + STEP;
  end

  always_ff @(posedge clk) begin
    if (acc_next >= clock_rate) begin
      acc   <= acc_next - clock_rate; // Keep the remainder for long-term accuracy
      pulse <= 1'b1;
    end else begin
      acc   <= acc_next;
      pulse <= 1'b0;
    end
  end

endmodule

// File: source/axis_pos_if.sv
/*
 * Axis position bus
 * Four captured positions plus the load strobe, stick selector to axis timer
 */
`timescale 1ns/1ps

interface axis_pos_if;

  joy_types_pkg::axis_pos_t j1x; // Player 1 x
  joy_types_pkg::axis_pos_t j1y;
  joy_types_pkg::axis_pos_t j2x; // Player 2 x
  joy_types_pkg::axis_pos_t j2y;
  logic                     load; // Port write, positions valid now

  modport source (output j1x, j1y, j2x, j2y, load);
  modport sink   (input  j1x, j1y, j2x, j2y, load);

endinterface

// File: source/joy_types_pkg.sv
/*
 * Joystick port data types
 * Widths of pad words, stick words, positions, counts and the port byte
 */
package joy_types_pkg;

  // Bit 0 right, 1 left, 2 down, 3 up, 4..7 but1..but4,
  // 8 start, 9 select, 10 R1, 11 L1, 12 R2, 13 L2
  typedef logic [13:0] pad_bits_t;

  // {y, x}, both signed bytes
  typedef logic [15:0] stick_word_t;

  typedef logic [7:0]  axis_pos_t;   // Unsigned axis position 0..255
  typedef logic [10:0] axis_count_t; // One-shot length, up to 1022
  typedef logic [27:0] rate_t;       // Clock rate in Hz, accumulator width

  // Game-port register, {buttons[3:0], axes[3:0]}
  typedef logic [7:0]  port_byte_t;

endpackage

// File: source/joy_cfg_pkg.sv
/*
 * Joystick port configuration
 * Controller modes, axis-count methods and accumulator rate steps
 */
package joy_cfg_pkg;

  // Controller type seen by the game
  typedef enum logic [1:0] {
    two_button  = 2'd0,
    four_button = 2'd1,
    gravis_pro  = 2'd2, // GrIP serial pad
    no_stick    = 2'd3  // Port reads all ones
  } pad_mode_e;

  // How the axis one-shot length is derived
  typedef enum logic [1:0] {
    timed_ibm   = 2'd0, // IBM formula on 1.1 us tick
    count_8_141 = 2'd1, // Paratrooper friendly range
    count_0_256 = 2'd2,
    count_6_256 = 2'd3
  } count_mode_e;

  // Half-period step for a 20 kHz GrIP clock, relative to clock_rate in Hz
  parameter logic [27:0] GRIP_STEP = 28'd40000;
  // 1/1.1us = 909091 Hz
  parameter logic [27:0] TICK_STEP = 28'd909091;

  // Stick deflection that counts as analog use
  parameter logic signed [7:0] ACTIVITY_THRESHOLD = 8'sd60;

endpackage
